// File: logic/blit_pkg.sv
package blit_pkg;

  // sprite art and rom geometry
  localparam int SPRITE_DIM   = 4;
  localparam int SPRITE_COUNT = 4;
  localparam int ROM_ROWS     = SPRITE_COUNT * SPRITE_DIM;
  localparam int ROW_W        = 2 * SPRITE_DIM;          // four 2-bit pixel codes
  localparam int ROM_ADDR_W   = $clog2(ROM_ROWS);
  localparam int ROW_IDX_W    = $clog2(SPRITE_DIM);
  localparam int FETCH_W      = $clog2(SPRITE_DIM + 1);  // counts one past the last row

  localparam logic [1:0] PIX_TRANSPARENT = 2'd2;
  localparam logic [1:0] PIX_WHITE       = 2'd1;

  // credit depths on both ports
  localparam int CMD_CREDITS = 2;
  localparam int CMD_PTR_W   = $clog2(CMD_CREDITS);
  localparam int CMD_CNT_W   = $clog2(CMD_CREDITS + 1);
  localparam int PX_CREDITS  = 4;
  localparam int PX_CNT_W    = $clog2(PX_CREDITS + 1);

  typedef enum logic [1:0] {
    OP_NOP    = 2'd0,
    OP_SPRITE = 2'd1,
    OP_FILL   = 2'd2
  } blit_op_e;

  typedef struct packed {
    logic [1:0]  id;
    logic [8:0]  x;
    logic [7:0]  y;
    logic [10:0] pad;
  } sprite_body_t;

  typedef struct packed {
    logic       colour;
    logic [8:0] x;
    logic [7:0] y;
    logic [3:0] width_m1;
    logic [3:0] height_m1;
    logic [3:0] pad;
  } fill_body_t;

  // same 30 body bits, read by op
  typedef union packed {
    sprite_body_t sprite;
    fill_body_t   fill;
  } cmd_body_u;

  typedef struct packed {
    blit_op_e  op;
    cmd_body_u body;
  } blit_cmd_t;

  typedef struct packed {
    logic [8:0] x;
    logic [7:0] y;
    logic       colour;
  } pixel_t;

endpackage

// File: logic/sprite_rom.sv
module sprite_rom (
  input  logic                           clk,
  input  logic [blit_pkg::ROM_ADDR_W-1:0] rom_addr,
  output logic [blit_pkg::ROW_W-1:0]      rom_row
);
  import blit_pkg::*;

  // row sprite*4 + r holds row r of that sprite, column c in bits 2c+1:2c
  logic [ROW_W-1:0] rom [ROM_ROWS];

  initial begin
    $readmemh("logic/sprite_rom.mem", rom);
  end

  always_ff @(posedge clk) begin
    rom_row <= rom[rom_addr];  // one cycle read latency
  end

endmodule

// File: logic/cmd_decoder.sv
module cmd_decoder (
  input  logic                clk,
  input  logic                reset,
  input  logic                cmd_valid,
  input  blit_pkg::blit_cmd_t cmd,
  input  logic                job_take,
  output logic                cmd_credit,
  output logic                job_valid,
  output blit_pkg::blit_cmd_t job
);
  import blit_pkg::*;

  blit_cmd_t            fifo_q [CMD_CREDITS];
  logic [CMD_PTR_W-1:0] wr_ptr;
  logic [CMD_PTR_W-1:0] rd_ptr;
  logic [CMD_CNT_W-1:0] count;
  logic                 push;
  logic                 pop;

  assign push = cmd_valid;              // host only sends while holding a credit
  assign pop  = job_take && job_valid;

  // head of queue is the job offered to the walker
  // nops are offered too and the walker turns them into an empty completion
  assign job_valid = (count != '0);
  assign job       = fifo_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // depth 2 wraps on its own
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count      <= count + CMD_CNT_W'(push) - CMD_CNT_W'(pop);
      cmd_credit <= pop;                  // credit back the cycle after the pop
    end
  end

  always_ff @(posedge clk) begin
    if (push) fifo_q[wr_ptr] <= cmd;
  end

  // a host that respects its credits can never hit a full queue
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> count != CMD_CNT_W'(CMD_CREDITS));

  // a returned credit stands for a slot that was just freed
  a_credit_needs_pop: assert property (@(posedge clk) disable iff (reset)
    cmd_credit |-> count != CMD_CNT_W'(CMD_CREDITS));

endmodule

// File: logic/pixel_walker.sv
module pixel_walker (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            job_valid,
  input  blit_pkg::blit_cmd_t             job,
  input  logic [blit_pkg::ROW_W-1:0]      rom_row,
  input  logic                            pix_ready,
  output logic                            job_take,
  output logic [blit_pkg::ROM_ADDR_W-1:0] rom_addr,
  output logic                            pix_valid,
  output blit_pkg::pixel_t                pix,
  output logic                            pix_last,
  output logic                            pix_empty
);
  import blit_pkg::*;

  typedef enum logic [1:0] {IDLE, FETCH, WALK, FINISH} state_e;

  state_e                state;
  blit_cmd_t             job_r;
  logic [FETCH_W-1:0]    fetch_cnt;
  logic [ROW_IDX_W-1:0]  fetch_row;
  logic [ROM_ROWS-1:0]   opaque;     // pixels of the sprite still to draw
  logic [ROM_ROWS-1:0]   white;
  logic [ROM_ADDR_W-1:0] first;      // row-major index of the next opaque pixel
  logic [3:0]            col;
  logic [3:0]            row;
  logic                  is_sprite;
  logic                  fill_end;
  logic                  move;

  assign job_take  = (state == IDLE) && job_valid;
  assign is_sprite = (job_r.op == OP_SPRITE);
  assign fill_end  = (col == job_r.body.fill.width_m1) && (row == job_r.body.fill.height_m1);
  assign move      = pix_valid && pix_ready;

  // address id*4 + row, data lands one cycle later
  assign rom_addr  = {job_r.body.sprite.id, fetch_cnt[ROW_IDX_W-1:0]};
  assign fetch_row = ROW_IDX_W'(fetch_cnt - 1'b1);

  // lowest set bit, so transparent pixels cost no output cycle
  always_comb begin
    first = '0;
    for (int i = ROM_ROWS - 1; i >= 0; i--) begin
      if (opaque[i]) first = ROM_ADDR_W'(i);
    end
  end

  assign pix_empty = (state == FINISH);
  assign pix_valid = pix_empty || ((state == WALK) && !(is_sprite && opaque == '0));
  assign pix_last  = pix_empty ||
                     (is_sprite ? ((opaque & (opaque - 1'b1)) == '0) : fill_end);

  always_comb begin
    if (is_sprite) begin
      pix.x      = job_r.body.sprite.x + 9'(first[ROW_IDX_W-1:0]);
      pix.y      = job_r.body.sprite.y + 8'(first[ROM_ADDR_W-1:ROW_IDX_W]);
      pix.colour = white[first];
    end else begin
      pix.x      = job_r.body.fill.x + 9'(col);  // wraps modulo 512
      pix.y      = job_r.body.fill.y + 8'(row);
      pix.colour = job_r.body.fill.colour;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (job_valid) begin
            case (job.op)
              OP_SPRITE: state <= FETCH;
              OP_FILL:   state <= WALK;
              default:   state <= FINISH;  // nop completes with no write
            endcase
          end
        end
        FETCH:   if (fetch_cnt == FETCH_W'(SPRITE_DIM)) state <= WALK;
        WALK: begin
          if (is_sprite && opaque == '0) state <= FINISH;  // all transparent
          else if (move && pix_last) state <= IDLE;
        end
        FINISH:  if (move) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (job_take) begin
      job_r     <= job;
      fetch_cnt <= '0;
      col       <= '0;
      row       <= '0;
    end
    if (state == FETCH) begin
      fetch_cnt <= fetch_cnt + 1'b1;
      if (fetch_cnt != '0) begin
        for (int c = 0; c < SPRITE_DIM; c++) begin
          opaque[{fetch_row, ROW_IDX_W'(c)}] <= (rom_row[2*c +: 2] != PIX_TRANSPARENT);
          white[{fetch_row, ROW_IDX_W'(c)}]  <= (rom_row[2*c +: 2] == PIX_WHITE);
        end
      end
    end
    if (move && state == WALK) begin
      if (is_sprite) begin
        opaque[first] <= 1'b0;
      end else if (col == job_r.body.fill.width_m1) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // the emitter may stall us for many cycles, the offered record must hold
  a_pix_stable: assert property (@(posedge clk) disable iff (reset)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix) && $stable(pix_last));

endmodule

// File: logic/pixel_emitter.sv
module pixel_emitter (
  input  logic             clk,
  input  logic             reset,
  input  logic             pix_valid,
  input  blit_pkg::pixel_t pix,
  input  logic             pix_last,
  input  logic             pix_empty,
  input  logic             px_credit,
  output logic             pix_ready,
  output logic             px_valid,
  output blit_pkg::pixel_t px,
  output logic             blit_done
);
  import blit_pkg::*;

  logic [PX_CNT_W-1:0] credits;
  logic                take;

  // the held record always goes out in the cycle it is valid, so a new one
  // fits whenever a credit is left over after this cycle's send
  assign pix_ready = (credits > PX_CNT_W'(px_valid));
  assign take      = pix_valid && pix_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      px_valid  <= 1'b0;
      blit_done <= 1'b0;
      credits   <= PX_CNT_W'(PX_CREDITS);  // framebuffer starts empty
    end else begin
      px_valid  <= take && !pix_empty;     // empty record only carries the done
      blit_done <= take && pix_last;
      credits   <= credits - PX_CNT_W'(px_valid) + PX_CNT_W'(px_credit);
    end
  end

  always_ff @(posedge clk) begin
    if (take) px <= pix;
  end

  // a write never goes out unless the framebuffer has room for it
  a_send_has_credit: assert property (@(posedge clk) disable iff (reset)
    px_valid |-> credits != '0);

  // framebuffer returns no more than it was sent
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    credits <= PX_CNT_W'(PX_CREDITS));

endmodule

// File: logic/blit_top.sv
module blit_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                cmd_valid,
  input  blit_pkg::blit_cmd_t cmd,
  input  logic                px_credit,
  output logic                cmd_credit,
  output logic                px_valid,
  output blit_pkg::pixel_t    px,
  output logic                blit_done
);
  import blit_pkg::*;

  // decoder to walker
  logic      job_valid;
  logic      job_take;
  blit_cmd_t job;

  // walker to rom
  logic [ROM_ADDR_W-1:0] rom_addr;
  logic [ROW_W-1:0]      rom_row;

  // walker to emitter
  logic   pix_valid;
  logic   pix_ready;
  logic   pix_last;
  logic   pix_empty;  // record carries only the completion
  pixel_t pix;

  cmd_decoder cmd_decoder_i (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .job_take   (job_take),
    .cmd_credit (cmd_credit),
    .job_valid  (job_valid),
    .job        (job)
  );

  pixel_walker pixel_walker_i (
    .clk       (clk),
    .reset     (reset),
    .job_valid (job_valid),
    .job       (job),
    .rom_row   (rom_row),
    .pix_ready (pix_ready),
    .job_take  (job_take),
    .rom_addr  (rom_addr),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_last  (pix_last),
    .pix_empty (pix_empty)
  );

  sprite_rom sprite_rom_i (
    .clk      (clk),
    .rom_addr (rom_addr),
    .rom_row  (rom_row)
  );

  pixel_emitter pixel_emitter_i (
    .clk       (clk),
    .reset     (reset),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_last  (pix_last),
    .pix_empty (pix_empty),
    .px_credit (px_credit),
    .pix_ready (pix_ready),
    .px_valid  (px_valid),
    .px        (px),
    .blit_done (blit_done)
  );

endmodule

// File: verif/blit_tb.sv
module blit_tb;
  import blit_pkg::*;

  localparam int WAIT_LIMIT = 400;  // cycles per wait
  localparam int QUIET      = 10;

  logic      clk = 1'b0;
  logic      reset;
  logic      cmd_valid;
  blit_cmd_t cmd;
  logic      px_credit = 1'b0;
  logic      cmd_credit;
  logic      px_valid;
  pixel_t    px;
  logic      blit_done;

  // golden test block being run
  logic [8*16-1:0] name;
  int              mode;
  int              exp_done;
  logic [31:0]     cmds [$];
  logic [18:0]     exp_px [$];  // {x, y, colour, last}

  // framebuffer model
  int unsigned delays [256];
  int unsigned return_due [$];
  logic        credit_next = 1'b0;
  logic        hold_credits;

  int unsigned cycle = 0;
  int sent_total = 0;
  int returned_total = 0;
  int credits_back = 0;
  int cmds_sent;
  int rec_idx;
  int dones;
  int errors;
  int tests;
  logic aborted;

  int    fd;
  int    n;
  string line;
  int    px_x, px_y, px_c, px_l;
  logic [31:0] word;

  blit_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .px_credit  (px_credit),
    .cmd_credit (cmd_credit),
    .px_valid   (px_valid),
    .px         (px),
    .blit_done  (blit_done)
  );

  always #20 clk = ~clk;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at %0t: %0s got %0h expected %0h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0s", why);
    aborted = 1'b1;
  endtask

  // outputs are registered, so values before the edge are settled
  always @(posedge clk) begin
    cycle++;
    credit_next = 1'b0;
    if (reset) begin
      if (cycle > 1) check_value({px_valid, blit_done, cmd_credit}, 0, "outputs in reset");
    end else begin
      if (cmd_credit) credits_back++;
      if (px_valid) begin
        return_due.push_back(cycle + delays[sent_total % 256]);
        sent_total++;
        check_value(sent_total - returned_total <= PX_CREDITS, 1, "writes within credits");
        if (rec_idx < exp_px.size()) check_value({px, blit_done}, exp_px[rec_idx], "write record");
        else check_value(1, 0, "write beyond the expected records");
        rec_idx++;
      end
      if (blit_done) dones++;
      if (!hold_credits && return_due.size() > 0 && return_due[0] <= cycle) begin
        void'(return_due.pop_front());
        returned_total++;
        credit_next = 1'b1;  // one credit per cycle at most
      end
    end
  end

  always @(negedge clk) px_credit = credit_next;

  task automatic run_test();
    int tries;
    int errs_before;
    int credits_base;
    errs_before  = errors;
    credits_base = credits_back;
    rec_idx      = 0;
    dones        = 0;
    hold_credits = (mode != 0);
    foreach (cmds[i]) begin
      tries = 0;
      while (CMD_CREDITS - cmds_sent + credits_back == 0) begin
        @(negedge clk);
        tries++;
        if (tries > WAIT_LIMIT) begin
          abort_run("timeout: no command credit came back");
          return;
        end
      end
      cmd_valid = 1'b1;
      cmd       = cmds[i];
      cmds_sent++;
      @(negedge clk);
      cmd_valid = 1'b0;
    end
    if (hold_credits) begin
      tries = 0;
      while (sent_total - returned_total < PX_CREDITS) begin
        @(negedge clk);
        tries++;
        if (tries > WAIT_LIMIT) begin
          abort_run("timeout: writes never used up the pixel credits");
          return;
        end
      end
      repeat (QUIET) @(negedge clk);
      check_value(sent_total - returned_total, PX_CREDITS, "writes outstanding while held");
      hold_credits = 1'b0;
    end
    tries = 0;
    while (dones < exp_done) begin
      @(negedge clk);
      tries++;
      if (tries > WAIT_LIMIT) begin
        abort_run("timeout: blit_done did not come for every command");
        return;
      end
    end
    repeat (QUIET) @(negedge clk);  // catch stray writes or completions
    check_value(rec_idx, exp_px.size(), "write count");
    check_value(dones, exp_done, "completion count");
    check_value(credits_back - credits_base, cmds.size(), "command credit pulses");
    tries = 0;
    while (return_due.size() > 0) begin
      @(negedge clk);
      tries++;
      if (tries > WAIT_LIMIT) begin
        abort_run("timeout: framebuffer credits were not all returned");
        return;
      end
    end
    tests++;
    $display("%0s: %0d writes, %0d completions, %0s", name, rec_idx, dones,
             (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    void'($urandom(28));
    foreach (delays[i]) delays[i] = $urandom % 6;  // credit return delay 0 to 5
    reset        = 1'b1;
    cmd_valid    = 1'b0;
    cmd          = '0;
    hold_credits = 1'b0;
    cmds_sent    = 0;
    rec_idx      = 0;
    dones        = 0;
    errors       = 0;
    tests        = 0;
    aborted      = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    fd = $fopen("verif/blit_golden.txt", "r");
    if (fd == 0) begin
      abort_run("golden file verif/blit_golden.txt could not be opened");
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        if (line.len() > 0) begin
          case (line[0])
            "t": begin
              n = $sscanf(line, "test %s %d", name, mode);
              if (n != 2) abort_run("bad test line in golden file");
              cmds.delete();
              exp_px.delete();
              exp_done = 0;
            end
            "c": begin
              n = $sscanf(line, "cmd %h", word);
              if (n != 1) abort_run("bad cmd line in golden file");
              cmds.push_back(word);
            end
            "p": begin
              n = $sscanf(line, "px %d %d %d %d", px_x, px_y, px_c, px_l);
              if (n != 4) abort_run("bad px line in golden file");
              exp_px.push_back({px_x[8:0], px_y[7:0], px_c[0], px_l[0]});
            end
            "d": n = $sscanf(line, "done %d", exp_done);
            "e": run_test();
            default: ;  // comments and blank lines
          endcase
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d mismatches", tests, errors);
    if (errors == 0 && tests > 0 && !aborted) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: logic/sprite_rom.mem
B6
AA
68
AA
A9
AA
AA
AA
5A
00
FF
A5
AA
AA
AA
AA

// File: verif/blit_golden.txt
# test <name> <pixel credits: 0 returned, 1 withheld first>, cmd <command word in hex>
# px <x> <y> <colour> <last write of its command>, done <completions>, end closes the test
test idle 0
done 0
end
test sprite 0
cmd 4050A000
px 11 20 1 0
px 12 20 0 0
px 10 22 0 0
px 13 22 1 1
done 1
end
test fill_wrap 0
cmd BFF1E210
px 511 30 1 0
px 0 30 1 0
px 1 30 1 0
px 511 31 1 0
px 0 31 1 0
px 1 31 1 1
done 1
end
test backpressure 1
cmd 86432210
px 100 50 0 0
px 101 50 0 0
px 102 50 0 0
px 100 51 0 0
px 101 51 0 0
px 102 51 0 1
done 1
end
test cmd_order 0
cmd 50282800
cmd A0000100
cmd 50384800
cmd 92CC8000
px 5 5 1 1
px 0 0 1 0
px 1 0 1 1
px 7 9 1 1
px 300 200 0 1
done 4
end
test completion 0
cmd 00000000
cmd 70000000
cmd 50081000
px 1 2 1 1
done 3
end

// File: sim.f
logic/blit_pkg.sv
logic/sprite_rom.sv
logic/cmd_decoder.sv
logic/pixel_walker.sv
logic/pixel_emitter.sv
logic/blit_top.sv
verif/blit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= blit_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
